// ==== mem_stage.f ====
mem_ops_pkg.sv
wb_bus_pkg.sv
wb_if.sv
lsu_align.sv
data_ram.sv
mem_access_ctrl.sv
wb_result_reg.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== Makefile ====
TOP = tb_mem_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mem_stage.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

// ==== tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
    import mem_ops_pkg::*;

    localparam int ram_addr_bits = 8;
    localparam int mem_bytes     = 8 << ram_addr_bits;
    localparam int item_count    = 600;
    // a few cycles per item, stretched by back-pressure
    localparam int cycle_limit   = 40 * item_count;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [63:0] in_pc;
    logic [31:0] in_inst;
    mem_op_e     in_op;
    logic [63:0] in_alu_result;
    logic [63:0] in_src2;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] out_pc;
    logic [31:0] out_inst;
    logic        out_rd_wen;
    logic [4:0]  out_rd_id;
    logic [63:0] out_rd_value;

    // reference memory, byte addressed
    logic [7:0]  model_mem [mem_bytes];
    // expected writebacks in input order
    logic [63:0] q_pc [$];
    logic [31:0] q_inst [$];
    logic        q_wen [$];
    logic [63:0] q_value [$];
    string       q_name [$];

    mem_op_e     op_pool [17];
    integer      seed;
    int          errors;
    int          checks;
    int          sent;
    int          received;
    int          cycles;
    logic        timed_out;
    logic        in_taken;
    logic        last_store;
    logic [31:0] last_addr;

    mem_stage_top #(
        .ram_addr_bits (ram_addr_bits)
    ) i_mem_stage_top (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_op         (in_op),
        .in_alu_result (in_alu_result),
        .in_src2       (in_src2),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_rd_wen    (out_rd_wen),
        .out_rd_id     (out_rd_id),
        .out_rd_value  (out_rd_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // reference model
    // **************************************************
    function automatic int op_size(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    // expected result of one accepted input, memory updated in order
    task automatic model_accept(input logic [63:0] pc, input logic [31:0] inst,
                                input mem_op_e op, input logic [63:0] alu,
                                input logic [63:0] src2);
        logic [63:0] value;
        logic [63:0] raw;
        logic        wen;
        int          size;
        int          addr;
        value = '0;
        raw   = '0;
        wen   = 1'b1;
        size  = op_size(op);
        addr  = int'(alu[15:0]);
        case (op)
            op_none:   wen = 1'b0;
            op_alu:    value = alu;
            op_alu_w:  value = 64'($signed(alu[31:0]));
            op_alu_hi: value = 64'($signed(alu[63:32]));
            op_link:   value = pc + 64'd4;
            op_csr:    value = src2;
            op_sb, op_sh, op_sw, op_sd: begin
                wen = 1'b0;
                // little endian, low byte at the lowest address
                for (int i = 0; i < size; i++)
                    model_mem[addr + i] = src2[8*i +: 8];
            end
            default: begin
                for (int i = 0; i < size; i++)
                    raw[8*i +: 8] = model_mem[addr + i];
                // signed loads copy the top loaded bit upward
                if ((op inside {op_lb, op_lh, op_lw}) && raw[8*size-1])
                    value = raw | ~((64'd1 << (8*size)) - 64'd1);
                else
                    value = raw;
            end
        endcase
        q_pc.push_back(pc);
        q_inst.push_back(inst);
        q_wen.push_back(wen);
        q_value.push_back(value);
        q_name.push_back(op.name());
    endtask

    // **************************************************
    // stimulus and checks
    // **************************************************
    task automatic make_item;
        int          pick;
        int          size;
        logic [31:0] addr;
        pick  = int'($unsigned($random(seed)) % 17);
        in_op = op_pool[pick];
        // stores often read back as a whole doubleword
        if (last_store && ($random(seed) & 1))
            in_op = op_ld;
        size = op_size(in_op);
        addr = ($unsigned($random(seed)) % mem_bytes) & ~32'(size - 1);
        if (last_store && in_op == op_ld)
            addr = last_addr & ~32'h7;
        // hot window so loads meet earlier stores
        else if ($random(seed) & 1)
            addr = addr & 32'h3f;
        in_pc   = {$random(seed), $random(seed)} & ~64'h3;
        in_inst = $random(seed);
        in_src2 = {$random(seed), $random(seed)};
        if (in_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
                          op_sb, op_sh, op_sw, op_sd})
            in_alu_result = {32'd0, addr};
        else
            in_alu_result = {$random(seed), $random(seed)};
        last_store = in_op inside {op_sb, op_sh, op_sw, op_sd};
        last_addr  = addr;
    endtask

    task automatic compare_value(input string test, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic check_output;
        string name;
        logic  wen;
        assert (q_name.size() != 0)
        else begin
            errors++;
            $display("output transfer with no pending input, pc %h", out_pc);
        end
        if (q_name.size() != 0) begin
            name = q_name.pop_front();
            wen  = q_wen.pop_front();
            compare_value({name, " pc"}, q_pc.pop_front(), out_pc);
            compare_value({name, " inst"}, 64'(q_inst[0]), 64'(out_inst));
            compare_value({name, " rd_id"}, 64'(q_inst[0][11:7]), 64'(out_rd_id));
            void'(q_inst.pop_front());
            compare_value({name, " rd_wen"}, 64'(wen), 64'(out_rd_wen));
            if (wen)
                compare_value({name, " rd_value"}, q_value[0], out_rd_value);
            void'(q_value.pop_front());
        end
    endtask

    // writeback fields stay clear without valid
    task automatic check_idle;
        compare_value("idle rd_wen", 64'd0, 64'(out_rd_wen));
        compare_value("idle rd_id", 64'd0, 64'(out_rd_id));
        compare_value("idle rd_value", 64'd0, out_rd_value);
    endtask

    initial begin
        seed          = 32'he22b_6811;
        op_pool       = '{op_none, op_alu, op_alu_w, op_alu_hi, op_link, op_csr,
                          op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
                          op_sb, op_sh, op_sw, op_sd};
        errors        = 0;
        checks        = 0;
        sent          = 0;
        received      = 0;
        cycles        = 0;
        timed_out     = 1'b0;
        in_taken      = 1'b0;
        last_store    = 1'b0;
        last_addr     = '0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_op         = op_none;
        in_alu_result = '0;
        in_src2       = '0;
        out_ready     = 1'b0;
        for (int i = 0; i < mem_bytes; i++)
            model_mem[i] = 8'h00;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        while ((sent < item_count || received < sent) && !timed_out) begin
            @(posedge clk);
            #1;
            if (in_taken)
                in_valid = 1'b0;
            // occasional gaps on the input side
            if (!in_valid && sent < item_count && ($unsigned($random(seed)) % 5) != 0) begin
                make_item();
                in_valid = 1'b1;
            end
            out_ready = ($unsigned($random(seed)) % 4) != 0;
            // settled, these values hold through the next edge
            @(negedge clk);
            in_taken = in_valid && in_ready;
            if (in_taken) begin
                model_accept(in_pc, in_inst, in_op, in_alu_result, in_src2);
                sent++;
            end
            if (out_valid && out_ready) begin
                check_output();
                received++;
            end else if (!out_valid) begin
                check_idle();
            end
            cycles++;
            if (cycles >= cycle_limit) begin
                timed_out = 1'b1;
                $display("timeout after %0d cycles, %0d of %0d results received",
                         cycles, received, sent);
            end
        end

        // drain, nothing more may come out
        @(posedge clk);
        #1;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!out_valid)
            else begin
                errors++;
                $display("extra output after all results, pc %h", out_pc);
            end
        end
        compare_value("output count", 64'(sent), 64'(received));

        $display("checks %0d, errors %0d, inputs %0d, outputs %0d, timeout %0d",
                 checks, errors, sent, received, timed_out);
        if (errors == 0 && !timed_out)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top #(
    parameter int ram_addr_bits = 8
) (
    input  wire                   clk,
    input  wire                   rst,
    // execute side
    input  wire                   in_valid,
    output logic                  in_ready,
    input  wire  [63:0]           in_pc,
    input  wire  [31:0]           in_inst,
    input  mem_ops_pkg::mem_op_e  in_op,
    input  wire  [63:0]           in_alu_result,
    input  wire  [63:0]           in_src2,
    // writeback side
    output logic                  out_valid,
    input  wire                   out_ready,
    output logic [63:0]           out_pc,
    output logic [31:0]           out_inst,
    output logic                  out_rd_wen,
    output logic [4:0]            out_rd_id,
    output logic [63:0]           out_rd_value
);
    import mem_ops_pkg::*;
    import wb_bus_pkg::*;

    mem_item_t           in_item;
    mem_item_t           acc_item;
    logic                acc_valid;
    logic                acc_ready;
    logic [wb_dat_w-1:0] store_data;
    logic [wb_sel_w-1:0] store_sel;
    logic [wb_dat_w-1:0] load_value_in;
    logic [wb_dat_w-1:0] load_value;

    wb_if i_wb_if ();

    // bundle the incoming fields
    assign in_item = '{pc: in_pc, inst: in_inst, op: in_op,
                       alu_result: in_alu_result, src2: in_src2};

    // **************************************************
    // access register and bus master
    // **************************************************
    mem_access_ctrl i_mem_access_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_item       (in_item),
        .bus           (i_wb_if.master),
        .store_data    (store_data),
        .store_sel     (store_sel),
        .load_value_in (load_value_in),
        .acc_valid     (acc_valid),
        .acc_ready     (acc_ready),
        .acc_item      (acc_item),
        .load_value    (load_value)
    );

    // lanes follow the held item
    lsu_align i_lsu_align (
        .op         (acc_item.op),
        .addr       (acc_item.alu_result[wb_adr_w-1:0]),
        .src2       (acc_item.src2),
        .rd_data    (i_wb_if.dat_r),
        .store_data (store_data),
        .store_sel  (store_sel),
        .load_value (load_value_in)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) i_data_ram (
        .clk (clk),
        .rst (rst),
        .bus (i_wb_if.slave)
    );

    // **************************************************
    // result register toward writeback
    // **************************************************
    wb_result_reg i_wb_result_reg (
        .clk          (clk),
        .rst          (rst),
        .acc_valid    (acc_valid),
        .acc_ready    (acc_ready),
        .acc_item     (acc_item),
        .load_value   (load_value),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_inst     (out_inst),
        .out_rd_wen   (out_rd_wen),
        .out_rd_id    (out_rd_id),
        .out_rd_value (out_rd_value)
    );

endmodule

`default_nettype wire

// ==== wb_result_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_result_reg (
    input  wire                     clk,
    input  wire                     rst,
    // from access stage
    input  wire                     acc_valid,
    output logic                    acc_ready,
    input  mem_ops_pkg::mem_item_t  acc_item,
    input  wire  [63:0]             load_value,
    // toward writeback
    output logic                    out_valid,
    input  wire                     out_ready,
    output logic [63:0]             out_pc,
    output logic [31:0]             out_inst,
    output logic                    out_rd_wen,
    output logic [4:0]              out_rd_id,
    output logic [63:0]             out_rd_value
);
    import mem_ops_pkg::*;

    logic        valid_q;
    logic [63:0] pc_q;
    logic [31:0] inst_q;
    logic        wen_q;
    logic [63:0] value_q;
    logic        wen;
    logic [63:0] wb_value;
    logic        take;

    // **************************************************
    // writeback value select
    // **************************************************
    always_comb begin
        case (acc_item.op)
            op_alu:    wb_value = acc_item.alu_result;
            op_alu_w:  wb_value = {{32{acc_item.alu_result[31]}}, acc_item.alu_result[31:0]};
            op_alu_hi: wb_value = {{32{acc_item.alu_result[63]}}, acc_item.alu_result[63:32]};
            op_link:   wb_value = acc_item.pc + 64'd4;
            // csr moves pass the operand through
            op_csr:    wb_value = acc_item.src2;
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld:
                       wb_value = load_value;
            default:   wb_value = '0;
        endcase
    end

    assign wen = (acc_item.op != op_none) && !is_store(acc_item.op);

    // free slot, or slot emptying this edge
    assign acc_ready = !valid_q || out_ready;
    assign take      = acc_valid && acc_ready;

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else if (take)
            valid_q <= 1'b1;
        else if (out_ready)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q    <= acc_item.pc;
            inst_q  <= acc_item.inst;
            wen_q   <= wen;
            value_q <= wb_value;
        end
    end

    // writeback fields read as zero when idle
    assign out_valid    = valid_q;
    assign out_pc       = pc_q;
    assign out_inst     = inst_q;
    assign out_rd_wen   = valid_q && wen_q;
    assign out_rd_id    = valid_q ? inst_q[11:7] : 5'd0;
    assign out_rd_value = valid_q ? value_q : 64'd0;

endmodule

`default_nettype wire

// ==== mem_access_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl (
    input  wire                              clk,
    input  wire                              rst,
    // from execute
    input  wire                              in_valid,
    output logic                             in_ready,
    input  mem_ops_pkg::mem_item_t           in_item,
    // data bus
    wb_if.master                             bus,
    // from lsu_align
    input  wire  [wb_bus_pkg::wb_dat_w-1:0]  store_data,
    input  wire  [wb_bus_pkg::wb_sel_w-1:0]  store_sel,
    input  wire  [wb_bus_pkg::wb_dat_w-1:0]  load_value_in,
    // toward result register
    output logic                             acc_valid,
    input  wire                              acc_ready,
    output mem_ops_pkg::mem_item_t           acc_item,
    output logic [wb_bus_pkg::wb_dat_w-1:0]  load_value
);
    import mem_ops_pkg::*;
    import wb_bus_pkg::*;

    mem_item_t           item_q;
    logic                held_q;
    logic                done_q;
    logic                cyc_q;
    logic                stb_q;
    logic [wb_dat_w-1:0] load_q;
    logic                item_mem;
    logic                leave;
    logic                accept;
    logic                bus_done;

    // **************************************************
    // handshake
    // **************************************************
    assign item_mem  = is_mem(item_q.op);
    // non-memory items are ready at once, memory items after ack
    assign acc_valid = held_q && (done_q || !item_mem);
    assign leave     = acc_valid && acc_ready;
    assign in_ready  = !held_q || leave;
    assign accept    = in_valid && in_ready;
    assign bus_done  = cyc_q && bus.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
            done_q <= 1'b0;
            cyc_q  <= 1'b0;
            stb_q  <= 1'b0;
        end else if (accept) begin
            held_q <= 1'b1;
            done_q <= 1'b0;
            // bus cycle starts right behind the new item
            cyc_q  <= is_mem(in_item.op);
            stb_q  <= is_mem(in_item.op);
        end else begin
            if (leave)
                held_q <= 1'b0;
            if (bus_done) begin
                cyc_q  <= 1'b0;
                stb_q  <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // item and load data
    always_ff @(posedge clk) begin
        if (accept)
            item_q <= in_item;
        // read data valid with ack
        if (bus_done)
            load_q <= load_value_in;
    end

    // **************************************************
    // bus drive, stable for the whole held item
    // **************************************************
    assign bus.cyc   = cyc_q;
    assign bus.stb   = stb_q;
    assign bus.we    = is_store(item_q.op);
    assign bus.adr   = item_q.alu_result[wb_adr_w-1:0];
    assign bus.dat_w = store_data;
    assign bus.sel   = store_sel;

    assign acc_item   = item_q;
    assign load_value = load_q;

    // strobe only inside a cycle, for a held memory item not yet done
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        bus.stb |-> bus.cyc && held_q && item_mem && !done_q);

    // strobe held until the slave answers
    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        bus.cyc && bus.stb && !bus.ack |=> bus.stb);

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int ram_addr_bits = 8
) (
    input  wire  clk,
    input  wire  rst,
    wb_if.slave  bus
);
    import wb_bus_pkg::*;

    localparam int depth = 2 ** ram_addr_bits;

    dword_lanes_u             mem [depth];
    dword_lanes_u             wr_lanes;
    logic [ram_addr_bits-1:0] idx;
    logic                     ack_q;
    logic                     req;

    // doubleword index sits above the byte offset
    assign idx      = bus.adr[ram_addr_bits+2:3];
    assign wr_lanes = bus.dat_w;
    // one request per strobe, none in the cycle after an ack
    assign req      = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            for (int i = 0; i < depth; i++)
                mem[i] <= '0;
        end else begin
            ack_q <= req;
            if (req && bus.we) begin
                // byte lanes picked by sel
                for (int b = 0; b < wb_sel_w; b++)
                    if (bus.sel[b])
                        mem[idx].bytes[b] <= wr_lanes.bytes[b];
            end
        end
    end

    // read data lands with ack
    always_ff @(posedge clk) begin
        if (req)
            bus.dat_r <= mem[idx];
    end

    assign bus.ack = ack_q;

endmodule

`default_nettype wire

// ==== lsu_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_align (
    input  mem_ops_pkg::mem_op_e             op,
    input  wire  [wb_bus_pkg::wb_adr_w-1:0]  addr,
    input  wire  [63:0]                      src2,
    input  wire  [wb_bus_pkg::wb_dat_w-1:0]  rd_data,
    output logic [wb_bus_pkg::wb_dat_w-1:0]  store_data,
    output logic [wb_bus_pkg::wb_sel_w-1:0]  store_sel,
    output logic [63:0]                      load_value
);
    import mem_ops_pkg::*;
    import wb_bus_pkg::*;

    dword_lanes_u wr_lanes;
    dword_lanes_u rd_lanes;
    logic [2:0]   ofs;

    // byte offset inside the doubleword
    assign ofs      = addr[2:0];
    assign rd_lanes = rd_data;

    // **************************************************
    // store side
    // **************************************************
    always_comb begin
        wr_lanes  = '0;
        store_sel = '0;
        case (op)
            op_sb: begin
                wr_lanes.bytes[ofs] = src2[7:0];
                store_sel[ofs]      = 1'b1;
            end
            op_sh: begin
                wr_lanes.halves[ofs[2:1]] = src2[15:0];
                store_sel                 = wb_sel_w'(2'b11) << ofs;
            end
            op_sw: begin
                wr_lanes.words[ofs[2]] = src2[31:0];
                store_sel              = wb_sel_w'(4'hf) << ofs;
            end
            op_sd: begin
                wr_lanes  = src2;
                store_sel = '1;
            end
            // loads and alu ops leave the lanes clear
            default: ;
        endcase
    end

    assign store_data = wr_lanes;

    // **************************************************
    // load side, pick lane then extend
    // **************************************************
    always_comb begin
        case (op)
            op_lb:   load_value = {{56{rd_lanes.bytes[ofs][7]}}, rd_lanes.bytes[ofs]};
            op_lbu:  load_value = {56'b0, rd_lanes.bytes[ofs]};
            op_lh:   load_value = {{48{rd_lanes.halves[ofs[2:1]][15]}},
                                   rd_lanes.halves[ofs[2:1]]};
            op_lhu:  load_value = {48'b0, rd_lanes.halves[ofs[2:1]]};
            op_lw:   load_value = {{32{rd_lanes.words[ofs[2]][31]}}, rd_lanes.words[ofs[2]]};
            op_lwu:  load_value = {32'b0, rd_lanes.words[ofs[2]]};
            op_ld:   load_value = rd_lanes;
            default: load_value = '0;
        endcase
    end

    // misaligned accesses are not supported by the bus side
    always_comb begin
        if (is_mem(op)) begin
            assert ((op inside {op_lb, op_lbu, op_sb})
                 || ((op inside {op_lh, op_lhu, op_sh}) && ofs[0] == 1'b0)
                 || ((op inside {op_lw, op_lwu, op_sw}) && ofs[1:0] == 2'b00)
                 || ((op inside {op_ld, op_sd}) && ofs == 3'b000))
                else $error("misaligned access, op %s addr %h", op.name(), addr);
        end
    end

endmodule

`default_nettype wire

// ==== wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_if;
    import wb_bus_pkg::*;

    // master side
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat_w;
    logic [wb_sel_w-1:0] sel;
    // slave side
    logic [wb_dat_w-1:0] dat_r;
    logic                ack;

    modport master (output cyc, stb, we, adr, dat_w, sel, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, dat_w, sel, output dat_r, ack);

endinterface

`default_nettype wire

// ==== wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

    // wishbone widths between access controller and ram
    localparam int wb_adr_w = 32;
    localparam int wb_dat_w = 64;
    localparam int wb_sel_w = wb_dat_w / 8;

    // one doubleword, viewed per lane size
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } dword_lanes_u;

endpackage

`default_nettype wire

// ==== mem_ops_pkg.sv ====
`default_nettype none

package mem_ops_pkg;

    // stage operation, decoded upstream into this compact form
    typedef enum logic [4:0] {
        op_none   = 5'd0,
        op_alu    = 5'd1,
        op_alu_w  = 5'd2,
        op_alu_hi = 5'd3,
        op_link   = 5'd4,
        op_csr    = 5'd5,
        // loads
        op_lb     = 5'd8,
        op_lh     = 5'd9,
        op_lw     = 5'd10,
        op_lbu    = 5'd11,
        op_lhu    = 5'd12,
        op_lwu    = 5'd13,
        op_ld     = 5'd14,
        // stores
        op_sb     = 5'd16,
        op_sh     = 5'd17,
        op_sw     = 5'd18,
        op_sd     = 5'd19
    } mem_op_e;

    // one instruction as it moves through the stage
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
        mem_op_e     op;
        logic [63:0] alu_result;
        logic [63:0] src2;
    } mem_item_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // anything that needs a bus cycle
    function automatic logic is_mem(mem_op_e op);
        return is_load(op) || is_store(op);
    endfunction

endpackage

`default_nettype wire
